//--- Bender.yml
package:
  name: fpu_cmp_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_cmp_pkg.sv
      - source/fpu_res_if.sv
      - source/fpu_cmp_core.sv
      - source/fpu_res_fifo.sv
      - source/fpu_cmp_retire.sv
      - source/fpu_cmp_unit.sv
      - target: test
        files:
          - test/fpu_cmp_unit_chk.sv
          - test/fpu_cmp_unit_tb.sv

//--- project.f
+incdir+source
source/fpu_cmp_pkg.sv
source/fpu_res_if.sv
source/fpu_cmp_core.sv
source/fpu_res_fifo.sv
source/fpu_cmp_retire.sv
source/fpu_cmp_unit.sv
test/fpu_cmp_unit_chk.sv
test/fpu_cmp_unit_tb.sv

//--- source/fpu_cmp_cfg.svh
`ifndef FPU_CMP_CFG_SVH
`define FPU_CMP_CFG_SVH

`default_nettype none

// single precision float layout
`define FPU_CMP_EXP_W 8
`define FPU_CMP_MAN_W 23

// result buffer entries
`define FPU_CMP_FIFO_DEPTH 4

`default_nettype wire

`endif

//--- source/fpu_cmp_core.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_core (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          v_i,
  input  fpu_cmp_pkg::fpu_cmp_op_e      op_i,
  input  logic [fpu_cmp_pkg::FPU_W-1:0] a_i,
  input  logic [fpu_cmp_pkg::FPU_W-1:0] b_i,
  fpu_res_if.writer                     res
);
  import fpu_cmp_pkg::*;

  fpu_word_u a_w;
  fpu_word_u b_w;

  logic a_zero;
  logic a_nan;
  logic a_snan;
  logic b_zero;
  logic b_nan;
  logic b_snan;
  logic snan_any;
  logic mag_lt;

  logic eq;
  logic lt;
  logic le;

  logic [FPU_W-1:0] min_w;
  logic [FPU_W-1:0] max_w;
  logic [FPU_W-1:0] sel_result;
  logic             sel_invalid;

  assign a_w = a_i;
  assign b_w = b_i;

  // operand classes
  assign a_zero = ~|a_w.f.exp & ~|a_w.f.man;
  assign b_zero = ~|b_w.f.exp & ~|b_w.f.man;
  assign a_nan  = &a_w.f.exp & |a_w.f.man;
  assign b_nan  = &b_w.f.exp & |b_w.f.man;
  // signaling when quiet bit is clear
  assign a_snan = a_nan & ~a_w.f.man[MAN_W-1];
  assign b_snan = b_nan & ~b_w.f.man[MAN_W-1];

  assign snan_any = a_snan | b_snan;

  // magnitude only, exponent above mantissa keeps ordering
  assign mag_lt = a_w.raw[FPU_W-2:0] < b_w.raw[FPU_W-2:0];

  always_comb begin
    eq = 1'b0;
    lt = 1'b0;
    le = 1'b0;
    if (!(a_nan || b_nan)) begin
      if (a_zero && b_zero) begin
        eq = 1'b1;
        le = 1'b1;
      end else begin
        eq = (a_w.raw == b_w.raw);
        case ({a_w.f.sign, b_w.f.sign})
          2'b00: begin
            lt = mag_lt;
            le = mag_lt | eq;
          end
          // positive a never below negative b
          2'b01: begin
            lt = 1'b0;
            le = 1'b0;
          end
          2'b10: begin
            lt = 1'b1;
            le = 1'b1;
          end
          // both negative, larger magnitude is smaller
          default: begin
            lt = ~mag_lt & ~eq;
            le = ~mag_lt | eq;
          end
        endcase
      end
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      min_w = FPU_QNAN;
      max_w = FPU_QNAN;
    end else if (a_nan) begin
      min_w = b_w.raw;
      max_w = b_w.raw;
    end else if (b_nan) begin
      min_w = a_w.raw;
      max_w = a_w.raw;
    end else if (a_zero && b_zero) begin
      // -0 orders below +0
      min_w = fpu_zero(a_w.f.sign | b_w.f.sign);
      max_w = fpu_zero(a_w.f.sign & b_w.f.sign);
    end else if (lt) begin
      min_w = a_w.raw;
      max_w = b_w.raw;
    end else begin
      min_w = b_w.raw;
      max_w = a_w.raw;
    end
  end

  always_comb begin
    sel_result  = '0;
    sel_invalid = 1'b0;
    case (op_i)
      EQ: begin
        sel_result[0] = eq;
        sel_invalid   = snan_any;
      end
      LT: begin
        sel_result[0] = lt;
        sel_invalid   = a_nan | b_nan;
      end
      LE: begin
        sel_result[0] = le;
        sel_invalid   = a_nan | b_nan;
      end
      MIN: begin
        sel_result  = min_w;
        sel_invalid = snan_any;
      end
      MAX: begin
        sel_result  = max_w;
        sel_invalid = snan_any;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      res.result  <= sel_result;
      res.invalid <= sel_invalid;
      res.op      <= op_i;
    end
  end

endmodule

`default_nettype wire

//--- source/fpu_cmp_pkg.sv
`include "fpu_cmp_cfg.svh"

`default_nettype none

package fpu_cmp_pkg;

  localparam int EXP_W = `FPU_CMP_EXP_W;
  localparam int MAN_W = `FPU_CMP_MAN_W;
  localparam int FPU_W = 1 + EXP_W + MAN_W;

  typedef enum logic [2:0] {
    EQ  = 3'd0,
    LT  = 3'd1,
    LE  = 3'd2,
    MIN = 3'd3,
    MAX = 3'd4
  } fpu_cmp_op_e;

  // same word seen as raw bits or as float fields
  typedef union packed {
    logic [FPU_W-1:0] raw;
    struct packed {
      logic             sign;
      logic [EXP_W-1:0] exp;
      logic [MAN_W-1:0] man;
    } f;
  } fpu_word_u;

  // canonical quiet nan, positive with only the quiet bit set
  localparam logic [FPU_W-1:0] FPU_QNAN = {
    1'b0,
    {EXP_W{1'b1}},
    1'b1,
    {(MAN_W-1){1'b0}}
  };

  function automatic logic [FPU_W-1:0] fpu_zero(input logic sign);
    return {sign, {(FPU_W-1){1'b0}}};
  endfunction

endpackage

`default_nettype wire

//--- source/fpu_cmp_retire.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_retire (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          pop_i,
  input  logic                          empty_i,
  input  logic [fpu_cmp_pkg::FPU_W-1:0] head_result_i,
  input  logic                          head_invalid_i,
  input  logic                          flags_clr_i,
  output logic                          pop_o,
  output logic                          res_v_o,
  output logic [fpu_cmp_pkg::FPU_W-1:0] res_o,
  output logic                          res_invalid_o,
  output logic                          nv_o
);
  import fpu_cmp_pkg::*;

  logic             res_v_q;
  logic [FPU_W-1:0] res_q;
  logic             res_invalid_q;
  logic             nv_q;

  // pop on empty is ignored
  assign pop_o = pop_i & ~empty_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_v_q <= 1'b0;
      nv_q    <= 1'b0;
    end else begin
      res_v_q <= pop_o;
      // sticky, new invalid beats a same cycle clear
      nv_q    <= (nv_q & ~flags_clr_i) | (pop_o & head_invalid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      res_q         <= head_result_i;
      res_invalid_q <= head_invalid_i;
    end
  end

  assign res_v_o       = res_v_q;
  assign res_o         = res_q;
  assign res_invalid_o = res_invalid_q;
  assign nv_o          = nv_q;

endmodule

`default_nettype wire

//--- source/fpu_cmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_unit (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          v_i,
  input  fpu_cmp_pkg::fpu_cmp_op_e      op_i,
  input  logic [fpu_cmp_pkg::FPU_W-1:0] a_i,
  input  logic [fpu_cmp_pkg::FPU_W-1:0] b_i,
  input  logic                          pop_i,
  input  logic                          flags_clr_i,
  output logic                          empty_o,
  output logic                          overflow_o,
  output logic                          res_v_o,
  output logic [fpu_cmp_pkg::FPU_W-1:0] res_o,
  output logic                          res_invalid_o,
  output logic                          nv_o
);
  import fpu_cmp_pkg::*;

  fpu_res_if res_bus ();

  logic             fifo_empty;
  logic             fifo_pop;
  logic [FPU_W-1:0] head_result;
  logic             head_invalid;

  fpu_cmp_core u_core (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .res      (res_bus.writer)
  );

  fpu_res_fifo u_fifo (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .wr             (res_bus.reader),
    .pop_i          (fifo_pop),
    .empty_o        (fifo_empty),
    .head_result_o  (head_result),
    .head_invalid_o (head_invalid),
    .flags_clr_i    (flags_clr_i),
    .overflow_o     (overflow_o)
  );

  fpu_cmp_retire u_retire (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .pop_i          (pop_i),
    .empty_i        (fifo_empty),
    .head_result_i  (head_result),
    .head_invalid_i (head_invalid),
    .flags_clr_i    (flags_clr_i),
    .pop_o          (fifo_pop),
    .res_v_o        (res_v_o),
    .res_o          (res_o),
    .res_invalid_o  (res_invalid_o),
    .nv_o           (nv_o)
  );

  assign empty_o = fifo_empty;

endmodule

`default_nettype wire

//--- source/fpu_res_fifo.sv
`include "fpu_cmp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fpu_res_fifo (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  fpu_res_if.reader                     wr,
  input  logic                          pop_i,
  output logic                          empty_o,
  output logic [fpu_cmp_pkg::FPU_W-1:0] head_result_o,
  output logic                          head_invalid_o,
  input  logic                          flags_clr_i,
  output logic                          overflow_o
);
  import fpu_cmp_pkg::*;

  localparam int DEPTH = `FPU_CMP_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [FPU_W-1:0] result_mem [DEPTH];
  logic             invalid_mem [DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;
  logic             overflow_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  assign pop  = pop_i & ~empty_o;
  // a pop this cycle frees the slot for a write on a full buffer
  assign push = wr.valid & (~full | pop);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // dropped write wins over clear
      overflow_q <= (overflow_q & ~flags_clr_i) | (wr.valid & ~push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      result_mem[wr_ptr]  <= wr.result;
      invalid_mem[wr_ptr] <= wr.invalid;
    end
  end

  assign head_result_o  = result_mem[rd_ptr];
  assign head_invalid_o = invalid_mem[rd_ptr];
  assign overflow_o     = overflow_q;

endmodule

`default_nettype wire

//--- source/fpu_res_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fpu_res_if;
  import fpu_cmp_pkg::*;

  logic             valid;
  logic [FPU_W-1:0] result;
  logic             invalid;
  // op travels along for waveform tracing
  fpu_cmp_op_e      op;

  modport writer (
    output valid,
    output result,
    output invalid,
    output op
  );

  modport reader (
    input valid,
    input result,
    input invalid,
    input op
  );

endinterface

`default_nettype wire

//--- test/fpu_cmp_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_unit_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic pop_i,
  input logic flags_clr_i,
  input logic empty_o,
  input logic overflow_o,
  input logic res_v_o,
  input logic nv_o
);

  int fail_cnt = 0;

  // two results in a row need two pops in a row
  a_res_v_pop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_v_o && $past(res_v_o) |-> $past(pop_i) && $past(pop_i, 2))
    else begin
      fail_cnt++;
      $error("res_v_o high on consecutive cycles without consecutive pops");
    end

  a_nv_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(nv_o) |-> $past(flags_clr_i))
    else begin
      fail_cnt++;
      $error("nv_o fell without flags_clr_i");
    end

  a_reset_vals: assert property (@(posedge clk_i)
    !arst_n_i |-> empty_o && !overflow_o)
    else begin
      fail_cnt++;
      $error("empty_o or overflow_o not at reset value");
    end

endmodule

bind fpu_cmp_unit fpu_cmp_unit_chk u_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .pop_i       (pop_i),
  .flags_clr_i (flags_clr_i),
  .empty_o     (empty_o),
  .overflow_o  (overflow_o),
  .res_v_o     (res_v_o),
  .nv_o        (nv_o)
);

`default_nettype wire

//--- test/fpu_cmp_unit_tb.sv
`include "fpu_cmp_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module fpu_cmp_unit_tb;
  import fpu_cmp_pkg::*;

  localparam int DEPTH          = `FPU_CMP_FIFO_DEPTH;
  localparam int RESET_CYCLES   = 8;
  localparam int CYCLE_NS       = 4;
  localparam int CYCLES_PER_VEC = 40;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    fpu_cmp_op_e op;
    logic [31:0] res;
    logic        inv;
  } vec_t;

  typedef struct packed {
    logic [31:0] res;
    logic        inv;
  } exp_t;

  logic        clk_i;
  logic        arst_n_i;
  logic        v_i;
  fpu_cmp_op_e op_i;
  logic [31:0] a_i;
  logic [31:0] b_i;
  logic        pop_i;
  logic        flags_clr_i;
  logic        empty_o;
  logic        overflow_o;
  logic        res_v_o;
  logic [31:0] res_o;
  logic        res_invalid_o;
  logic        nv_o;

  vec_t vecs[$];
  exp_t sb[$];
  int   writes;
  int   pops;
  int   pop_gap;
  int   idx;
  logic nv_exp;
  logic table_ready;

  fpu_cmp_unit UUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .v_i           (v_i),
    .op_i          (op_i),
    .a_i           (a_i),
    .b_i           (b_i),
    .pop_i         (pop_i),
    .flags_clr_i   (flags_clr_i),
    .empty_o       (empty_o),
    .overflow_o    (overflow_o),
    .res_v_o       (res_v_o),
    .res_o         (res_o),
    .res_invalid_o (res_invalid_o),
    .nv_o          (nv_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic add_vec(input logic [31:0] a, input logic [31:0] b, input fpu_cmp_op_e op,
                         input logic [31:0] res, input logic inv);
    vecs.push_back(vec_t'{a, b, op, res, inv});
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // one cycle of stimulus, called 0.5 ns after a rising edge
  task automatic step(input logic wr, input vec_t v, input logic may_pop);
    logic rd;
    rd = 1'b0;
    if (may_pop && pop_gap > 0) begin
      pop_gap--;
    end else if (may_pop && !empty_o) begin
      rd = 1'b1;
      pop_gap = $urandom % 4;
      pops++;
    end
    if (wr) begin
      sb.push_back(exp_t'{v.res, v.inv});
      writes++;
    end
    v_i = wr;
    op_i = v.op;
    a_i = v.a;
    b_i = v.b;
    pop_i = rd;
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic drain();
    while (sb.size() != 0) begin
      step(1'b0, vecs[0], 1'b1);
    end
    pop_i = 1'b0;
  endtask

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk_i) begin
    if (arst_n_i === 1'b1 && res_v_o === 1'b1) begin
      assert (sb.size() != 0) else begin
        $display("result %h delivered at %0t with no operation pending", res_o, $time);
        stop_on_error();
      end
      if (sb[0].inv) begin
        nv_exp = 1'b1;
      end
      assert (res_o === sb[0].res) else begin
        $display("mismatch at %0t: res_o got %h expected %h", $time, res_o, sb[0].res);
        stop_on_error();
      end
      check_bit("res_invalid_o", res_invalid_o, sb[0].inv);
      check_bit("nv_o", nv_o, nv_exp);
      void'(sb.pop_front());
    end
  end

  initial begin
    wait (table_ready === 1'b1);
    #(((vecs.size() + DEPTH + 1) * CYCLES_PER_VEC + RESET_CYCLES) * CYCLE_NS);
    $display("timeout: the run did not finish in the allowed time");
    stop_on_error();
  end

  initial begin
    void'($urandom(32'h8dee415f));
    arst_n_i = 1'b0;
    v_i = 1'b0;
    op_i = EQ;
    a_i = '0;
    b_i = '0;
    pop_i = 1'b0;
    flags_clr_i = 1'b0;
    writes = 0;
    pops = 0;
    pop_gap = 0;
    nv_exp = 1'b0;
    // first five have distinct results for the overflow burst
    add_vec(32'h3F800000, 32'h40000000, MIN, 32'h3F800000, 1'b0);
    add_vec(32'hBF800000, 32'hC0000000, MAX, 32'hBF800000, 1'b0);
    add_vec(32'h3F000000, 32'h40000000, MAX, 32'h40000000, 1'b0);
    add_vec(32'hC0000000, 32'h3F800000, MIN, 32'hC0000000, 1'b0);
    add_vec(32'h3F800000, 32'h3F800000, EQ,  32'h00000001, 1'b0);
    add_vec(32'h3F800000, 32'h40000000, LT,  32'h00000001, 1'b0);
    add_vec(32'h3F800000, 32'hBF800000, LE,  32'h00000000, 1'b0);
    add_vec(32'hC0000000, 32'hBF800000, LT,  32'h00000001, 1'b0);
    add_vec(32'hBF800000, 32'hC0000000, LE,  32'h00000000, 1'b0);
    // signed zeros
    add_vec(32'h00000000, 32'h80000000, EQ,  32'h00000001, 1'b0);
    add_vec(32'h00000000, 32'h80000000, MIN, 32'h80000000, 1'b0);
    add_vec(32'h00000000, 32'h80000000, MAX, 32'h00000000, 1'b0);
    add_vec(32'h80000000, 32'h80000000, MAX, 32'h80000000, 1'b0);
    // quiet and signaling nans
    add_vec(32'h7FC00000, 32'h3F800000, EQ,  32'h00000000, 1'b0);
    add_vec(32'h7FC00000, 32'h3F800000, LT,  32'h00000000, 1'b1);
    add_vec(32'h3F800000, 32'h7FC00000, LE,  32'h00000000, 1'b1);
    add_vec(32'h7F800001, 32'h3F800000, EQ,  32'h00000000, 1'b1);
    add_vec(32'h7FC00000, 32'h40000000, MIN, 32'h40000000, 1'b0);
    add_vec(32'h3F800000, 32'h7FC00000, MAX, 32'h3F800000, 1'b0);
    // neither nan operand equals the canonical one
    add_vec(32'hFFC00001, 32'h7FC00002, MIN, 32'h7FC00000, 1'b0);
    add_vec(32'h7F800001, 32'hFFC00000, MAX, 32'h7FC00000, 1'b1);
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;
    check_bit("empty_o", empty_o, 1'b1);

    // keep at most DEPTH entries outstanding so nothing is dropped
    idx = 0;
    while (idx < vecs.size()) begin
      if (writes - pops < DEPTH) begin
        step(1'b1, vecs[idx], 1'b1);
        idx++;
      end else begin
        step(1'b0, vecs[idx], 1'b1);
      end
    end
    drain();
    check_bit("overflow_o", overflow_o, 1'b0);

    check_bit("nv_o", nv_o, 1'b1);
    flags_clr_i = 1'b1;
    step(1'b0, vecs[0], 1'b0);
    flags_clr_i = 1'b0;
    nv_exp = 1'b0;
    check_bit("nv_o", nv_o, 1'b0);

    // burst of DEPTH + 1 writes, last one is dropped
    for (int i = 0; i < DEPTH + 1; i++) begin
      if (i < DEPTH) begin
        step(1'b1, vecs[i], 1'b0);
      end else begin
        v_i = 1'b1;
        op_i = vecs[i].op;
        a_i = vecs[i].a;
        b_i = vecs[i].b;
        @(posedge clk_i);
        #0.5;
      end
    end
    for (int i = 0; i < 4 && !overflow_o; i++) begin
      step(1'b0, vecs[0], 1'b0);
    end
    check_bit("overflow_o", overflow_o, 1'b1);
    drain();
    repeat (4) step(1'b0, vecs[0], 1'b0);
    check_bit("empty_o", empty_o, 1'b1);
    flags_clr_i = 1'b1;
    step(1'b0, vecs[0], 1'b0);
    flags_clr_i = 1'b0;
    check_bit("overflow_o", overflow_o, 1'b0);

    if (UUT.u_chk.fail_cnt != 0) begin
      $display("bound assertions reported %0d failures", UUT.u_chk.fail_cnt);
      stop_on_error();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
